//--- ppuPkg.sv
`default_nettype none

package ppuPkg;

	////////////////////////////////////////////////////////////
	// Memory geometry
	////////////////////////////////////////////////////////////

	// Sprite attribute memory holds one 32-bit word per sprite
	localparam int oamEntries = 64;
	localparam int oamAddrBits = 6;

	// Four byte lanes per sprite word
	localparam int oamLanes = 4;

	// Tile table and attribute table share this depth
	localparam int bgEntries = 1024;
	localparam int bgAddrBits = 10;

	////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////

	// Opcodes issued by the CPU
	// Values 8 to 15 are not defined and never write
	typedef enum logic [3:0] {
		opNone           = 4'h0,
		opRemoveSprite   = 4'h1,
		opSpriteLocation = 4'h2,
		opSpriteLoad     = 4'h3,
		opSpriteTile     = 4'h4,
		opBgTile         = 4'h5,
		opSpriteAttr     = 4'h6,
		opBgAttr         = 4'h7
	} ppuOp_e;

	// One instruction from the CPU
	typedef struct packed {
		ppuOp_e                opcode;
		logic [bgAddrBits-1:0] index;
		logic [31:0]           value;
	} ppuInstr_t;

	////////////////////////////////////////////////////////////
	// Write requests
	////////////////////////////////////////////////////////////

	// Sprite entry write
	// Lane 3 is Y position, lane 2 tile, lane 1 attribute, lane 0 X position
	typedef struct packed {
		logic [oamLanes-1:0]    laneEn;
		logic [oamAddrBits-1:0] addr;
		logic [31:0]            data;
	} oamWrite_t;

	// Background write
	// Address and data are shared by both tables
	typedef struct packed {
		logic                  tileEn;
		logic                  attrEn;
		logic [bgAddrBits-1:0] addr;
		logic [7:0]            data;
	} bgWrite_t;

endpackage

`default_nettype wire

//--- cpuPpuInterface.sv
`timescale 1ns/10ps
`default_nettype none

// Instruction decoder
// Turns one CPU instruction into write requests for the sprite
// memory and the two background tables, all in the same cycle
module cpuPpuInterface (
	input  ppuPkg::ppuInstr_t instr,
	input  logic              instrValid,
	output ppuPkg::oamWrite_t oamWr,
	output ppuPkg::bgWrite_t  bgWr
);

	////////////////////////////////////////////////////////////
	// Opcode decode
	////////////////////////////////////////////////////////////

	// Sprite fields touched by the opcode
	logic [ppuPkg::oamLanes-1:0] laneMask;

	// Sprite removal writes all ones
	logic forceOnes;

	// Background table selects
	logic tileSel;
	logic attrSel;

	always_comb begin
		// Nothing selected unless the opcode asks for it
		laneMask = '0;
		forceOnes = 1'b0;
		tileSel = 1'b0;
		attrSel = 1'b0;

		case (instr.opcode)
			ppuPkg::opRemoveSprite: begin
				// Whole entry cleared to the removed pattern
				laneMask = 4'b1111;
				forceOnes = 1'b1;
			end

			ppuPkg::opSpriteLocation: begin
				// Y and X bytes only
				laneMask = 4'b1001;
			end

			ppuPkg::opSpriteLoad: begin
				// Full sprite entry
				laneMask = 4'b1111;
			end

			ppuPkg::opSpriteTile: begin
				// Tile byte only
				laneMask = 4'b0100;
			end

			ppuPkg::opSpriteAttr: begin
				// Attribute byte only
				laneMask = 4'b0010;
			end

			ppuPkg::opBgTile: begin
				tileSel = 1'b1;
			end

			ppuPkg::opBgAttr: begin
				attrSel = 1'b1;
			end

			default: begin
				// opNone and undefined codes write nothing
				laneMask = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Sprite write request
	////////////////////////////////////////////////////////////

	always_comb begin
		// Only the low index bits address a sprite
		oamWr.addr = instr.index[ppuPkg::oamAddrBits-1:0];

		if (forceOnes) begin
			oamWr.data = '1;
		end else begin
			oamWr.data = instr.value;
		end

		// No strobe without a valid instruction
		oamWr.laneEn = instrValid ? laneMask : '0;
	end

	////////////////////////////////////////////////////////////
	// Background write request
	////////////////////////////////////////////////////////////

	always_comb begin
		// Full index addresses the tables
		bgWr.addr = instr.index;

		// One byte per table entry
		bgWr.data = instr.value[7:0];

		bgWr.tileEn = instrValid & tileSel;
		bgWr.attrEn = instrValid & attrSel;
	end

endmodule

`default_nettype wire

//--- oamMemory.sv
`timescale 1ns/10ps
`default_nettype none

// Sprite attribute memory
// 64 words of 32 bits with a write enable per byte lane
module oamMemory (
	input  logic                           clk,
	input  logic                           rstN,
	input  ppuPkg::oamWrite_t              wr,
	input  logic [ppuPkg::oamAddrBits-1:0] rdAddr,
	output logic [31:0]                    rdData
);

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	// One word per sprite
	// Byte 3 Y position, byte 2 tile, byte 1 attribute, byte 0 X position
	logic [31:0] spriteMem [ppuPkg::oamEntries];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// Each lane written on its own
	// Untouched lanes keep the other sprite fields
	always_ff @(posedge clk) begin
		for (int lane = 0; lane < ppuPkg::oamLanes; lane++) begin
			if (wr.laneEn[lane]) begin
				spriteMem[wr.addr][lane*8 +: 8] <= wr.data[lane*8 +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Registered read, one cycle latency
	// A write to the same address on this edge is not seen yet
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdData <= '0;
		end else begin
			rdData <= spriteMem[rdAddr];
		end
	end

endmodule

`default_nettype wire

//--- bgTableMemory.sv
`timescale 1ns/10ps
`default_nettype none

// Background table
// 1024 bytes, used for both the tile table and the attribute table
module bgTableMemory (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          wrEn,
	input  logic [ppuPkg::bgAddrBits-1:0] wrAddr,
	input  logic [7:0]                    wrData,
	input  logic [ppuPkg::bgAddrBits-1:0] rdAddr,
	output logic [7:0]                    rdData
);

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	logic [7:0] tableMem [ppuPkg::bgEntries];

	// Single byte write
	always_ff @(posedge clk) begin
		if (wrEn) begin
			tableMem[wrAddr] <= wrData;
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	// Old contents returned on a same-edge write
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rdData <= '0;
		end else begin
			rdData <= tableMem[rdAddr];
		end
	end

endmodule

`default_nettype wire

//--- ppuVideoMemory.sv
`timescale 1ns/10ps
`default_nettype none

// Video memory write path
// Decoder feeding the sprite memory and both background tables
module ppuVideoMemory (
	input  logic                           clk,
	input  logic                           rstN,
	input  ppuPkg::ppuInstr_t              instr,
	input  logic                           instrValid,
	input  logic [ppuPkg::oamAddrBits-1:0] oamRdAddr,
	input  logic [ppuPkg::bgAddrBits-1:0]  bgRdAddr,
	output logic [31:0]                    oamRdData,
	output logic [7:0]                     bgTileData,
	output logic [7:0]                     bgAttrData
);

	// Decoded write requests
	ppuPkg::oamWrite_t oamWr;
	ppuPkg::bgWrite_t  bgWr;

	////////////////////////////////////////////////////////////
	// Decoder
	////////////////////////////////////////////////////////////

	cpuPpuInterface u_cpuPpuInterface (
		.instr      (instr),
		.instrValid (instrValid),
		.oamWr      (oamWr),
		.bgWr       (bgWr)
	);

	////////////////////////////////////////////////////////////
	// Stores
	////////////////////////////////////////////////////////////

	oamMemory u_oamMemory (
		.clk    (clk),
		.rstN   (rstN),
		.wr     (oamWr),
		.rdAddr (oamRdAddr),
		.rdData (oamRdData)
	);

	// Tile table strobed by tileEn
	bgTableMemory u_bgTileTable (
		.clk    (clk),
		.rstN   (rstN),
		.wrEn   (bgWr.tileEn),
		.wrAddr (bgWr.addr),
		.wrData (bgWr.data),
		.rdAddr (bgRdAddr),
		.rdData (bgTileData)
	);

	// Attribute table, same address and data, strobed by attrEn
	bgTableMemory u_bgAttrTable (
		.clk    (clk),
		.rstN   (rstN),
		.wrEn   (bgWr.attrEn),
		.wrAddr (bgWr.addr),
		.wrData (bgWr.data),
		.rdAddr (bgRdAddr),
		.rdData (bgAttrData)
	);

endmodule

`default_nettype wire

//--- tbPpuVideoMemory.sv
`timescale 1ns/10ps
`default_nettype none

// Self-checking testbench for the video memory write path
// Commands and expected read data come from tbPpuVideoMemoryInput.txt
module tbPpuVideoMemory;

	////////////////////////////////////////////////////////////
	// DUT signals
	////////////////////////////////////////////////////////////

	logic                           clk;
	logic                           rstN;
	ppuPkg::ppuInstr_t              instr;
	logic                           instrValid;
	logic [ppuPkg::oamAddrBits-1:0] oamRdAddr;
	logic [ppuPkg::bgAddrBits-1:0]  bgRdAddr;
	logic [31:0]                    oamRdData;
	logic [7:0]                     bgTileData;
	logic [7:0]                     bgAttrData;

	// Raised once the command file is worked through
	logic done = 1'b0;

	ppuVideoMemory u_ppuVideoMemory (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.oamRdAddr  (oamRdAddr),
		.bgRdAddr   (bgRdAddr),
		.oamRdData  (oamRdData),
		.bgTileData (bgTileData),
		.bgAttrData (bgAttrData)
	);

	// 4 ns clock period
	always begin
		#2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic abortRun();
		$display("Test failed");
		$fatal(1);
	endtask

	// Sprite read data
	task automatic checkOam(input string sigName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h got %h", sigName, expected, actual);
			abortRun();
		end
	endtask

	// Background table read data
	task automatic checkBg(input string sigName, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected %h got %h", sigName, expected, actual);
			abortRun();
		end
	endtask

	// One instruction, held for one cycle from a falling edge
	task automatic driveInstr(input logic [3:0] op, input logic [9:0] idx,
			input logic [31:0] val, input logic vld);
		instr.opcode = ppuPkg::ppuOp_e'(op);
		instr.index = idx;
		instr.value = val;
		instrValid = vld;
		@(posedge clk);
		@(negedge clk);
	endtask

	// Launch a read at the next rising edge, compare at the falling edge after it
	task automatic readAndCheck(input string target, input logic [9:0] addr,
			input logic [31:0] expected);
		instrValid = 1'b0;
		if (target == "oam") begin
			oamRdAddr = addr[ppuPkg::oamAddrBits-1:0];
		end else if (target == "tile" || target == "attr") begin
			bgRdAddr = addr;
		end else begin
			$display("Unknown read target %s in the command file", target);
			abortRun();
		end
		@(posedge clk);
		@(negedge clk);
		if (target == "oam") begin
			checkOam("oamRdData", expected, oamRdData);
		end else if (target == "tile") begin
			checkBg("bgTileData", expected[7:0], bgTileData);
		end else begin
			checkBg("bgAttrData", expected[7:0], bgAttrData);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin : mainSequence
		int          fd;
		int          code;
		int          settleCycles;
		string       line;
		string       cmd;
		string       target;
		logic [3:0]  opVal;
		logic [9:0]  idxVal;
		logic [31:0] valueVal;
		logic        validVal;
		logic [31:0] expVal;

		// Every input idle, reset held
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		oamRdAddr = '0;
		bgRdAddr = '0;

		fd = $fopen("tbPpuVideoMemoryInput.txt", "r");
		if (fd == 0) begin
			$display("Could not open the command file tbPpuVideoMemoryInput.txt");
			abortRun();
		end

		// Four cycles of reset, released on a falling edge
		repeat (4) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		// Read registers must be known before checking, up to 100 cycles
		settleCycles = 0;
		while ($isunknown({oamRdData, bgTileData, bgAttrData}) && settleCycles < 100) begin
			@(negedge clk);
			settleCycles++;
		end
		if (settleCycles >= 100) begin
			$display("Read data did not settle after reset");
			abortRun();
		end

		// Reset values before any write
		checkOam("oamRdData", 32'h0, oamRdData);
		checkBg("bgTileData", 8'h0, bgTileData);
		checkBg("bgAttrData", 8'h0, bgAttrData);

		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			// Blank lines and comment lines skipped
			if (code > 1 && line.getc(0) != "#") begin
				code = $sscanf(line, "%s", cmd);
				if (cmd == "wr") begin
					code = $sscanf(line, "%s %h %h %h %h", cmd, opVal, idxVal, valueVal,
						validVal);
					if (code != 5) begin
						$display("Malformed write line in the command file: %s", line);
						abortRun();
					end
					driveInstr(opVal, idxVal, valueVal, validVal);
				end else if (cmd == "rd") begin
					code = $sscanf(line, "%s %s %h %h", cmd, target, idxVal, expVal);
					if (code != 4) begin
						$display("Malformed read line in the command file: %s", line);
						abortRun();
					end
					readAndCheck(target, idxVal, expVal);
				end else begin
					$display("Unknown command %s in the command file", cmd);
					abortRun();
				end
			end
		end

		$fclose(fd);
		instrValid = 1'b0;
		done = 1'b1;
		$display("Test completed successfully");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////

	// Whole command file within 10000 cycles
	initial begin : watchdog
		int cycles;

		cycles = 0;
		while (!done && cycles < 10000) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("Timeout, the command file was not finished within 10000 cycles");
			$display("Test failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- tbPpuVideoMemoryInput.txt
# wr <opcode> <index> <value> <instrValid>       all fields hex
# rd <oam|tile|attr> <address> <expected data>   all fields hex
# Full sprite load, then partial lane updates of entry 5
wr 3 005 11223344 1
rd oam 05 11223344
wr 2 005 AABBCCDD 1
rd oam 05 AA2233DD
wr 4 005 01020304 1
rd oam 05 AA0233DD
wr 6 005 F0E0D0C0 1
rd oam 05 AA02D0DD
# Neighbours, index 046 lands on entry 6
wr 3 004 5A5A5A5A 1
wr 3 046 76543210 1
rd oam 04 5A5A5A5A
rd oam 06 76543210
# Removal ignores the value field
wr 1 005 00000000 1
rd oam 05 FFFFFFFF
rd oam 04 5A5A5A5A
rd oam 06 76543210
# Tile and attribute tables at the same index
wr 5 123 000000A7 1
wr 7 123 FFFFFF3C 1
rd tile 123 A7
rd attr 123 3C
wr 5 3FF 12345699 1
wr 7 000 00000042 1
rd tile 3FF 99
rd attr 000 42
# No effect from idle, opNone and undefined opcodes
wr 3 004 DEADBEEF 0
wr 5 123 000000EE 0
wr 0 004 DEADBEEF 1
wr 8 004 DEADBEEF 1
wr F 123 DEADBEEF 1
wr 8 006 CAFEF00D 1
rd oam 04 5A5A5A5A
rd oam 06 76543210
rd oam 05 FFFFFFFF
rd tile 123 A7
rd attr 123 3C
# Back-to-back instructions
wr 3 010 01010101 1
wr 3 011 02020202 1
wr 2 010 A0B0C0D0 1
wr 5 200 00000055 1
wr 7 200 00000066 1
wr 6 011 00007700 1
rd oam 11 02027702
rd oam 10 A00101D0
rd tile 200 55
rd attr 200 66
wr 5 201 000000C3 1
rd tile 201 C3

//--- sources.f
ppuPkg.sv
cpuPpuInterface.sv
oamMemory.sv
bgTableMemory.sv
ppuVideoMemory.sv
tbPpuVideoMemory.sv
